/* dmCache.f */
+incdir+include
src/dmCachePkg.sv
src/tagDirectory.sv
src/lineStore.sv
src/fillController.sv
src/responseHold.sv
src/dmCache.sv
verif/arbiterStub.sv
verif/dmCacheTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Build the dmCache testbench with Verilator and run it
# The run counts as passed only if the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f dmCache.f --top-module dmCacheTb -o dmCacheSim \
   && ./obj_dir/dmCacheSim | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

/* verif/dmCacheTb.sv */
`include "dmCache_settings.svh"

module dmCacheTb;

   logic                 cacheCoreBus;
   logic                 rstN;
   logic                 reqCyc;
   dmCachePkg::coreReqT  req;
   logic                 reqAck;
   logic                 respCyc;
   dmCachePkg::coreRespT resp;
   logic                 respAck;
   logic                 memReqCyc;
   dmCachePkg::memReqT   memReq;
   logic                 memReqAck;
   logic                 memRespCyc;
   dmCachePkg::memRespT  memResp;
   logic                 memRespAck;
   logic                 stubStuck;

   // Reference directory with one entry per line
   logic                      modelValid [1 << `DMC_INDEX_BITS];
   logic [`DMC_TAG_BITS-1:0]  modelTag [1 << `DMC_INDEX_BITS];
   // Small tag pool so hits and conflicts both happen
   logic [`DMC_TAG_BITS-1:0]  tagPool [3];
   logic [`DMC_ADDR_BITS-1:0] randAddrs [200];
   int unsigned               seedValue;

   // Arbiter request handshakes seen so far
   int                        memReqCount = 0;
   logic [`DMC_ADDR_BITS-1:0] lastMemAddr;

   dmCache dmCache_i (.*);

   arbiterStub arbiterStub_i (
      .cacheCoreBus (cacheCoreBus),
      .memReqCyc    (memReqCyc),
      .memReq       (memReq),
      .memReqAck    (memReqAck),
      .memRespCyc   (memRespCyc),
      .memResp      (memResp),
      .memRespAck   (memRespAck),
      .stuck        (stubStuck)
   );

   initial begin
      cacheCoreBus = 1'b0;
      forever #10 cacheCoreBus = ~cacheCoreBus;
   end

   // Record each accepted line request
   always @(posedge cacheCoreBus) begin
      if (memReqCyc && memReqAck) begin
         memReqCount <= memReqCount + 1;
         lastMemAddr <= memReq.addr;
      end
   end

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic checkValue(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
      if (actual !== expected) begin
         abortRun($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected));
      end
   endtask

   // Memory contents as the arbiter defines them
   function automatic logic [`DMC_WORD_BITS-1:0] expectedWord(
      input logic [`DMC_ADDR_BITS-1:0] addr);
      return {addr, ~addr};
   endfunction

   function automatic logic [`DMC_ADDR_BITS-1:0] makeAddr(input int tagSel, input int index,
                                                          input int offset);
      dmCachePkg::addrFieldsT f;
      f.tag    = tagPool[tagSel];
      f.index  = `DMC_INDEX_BITS'(index);
      f.offset = `DMC_OFFSET_BITS'(offset);
      return f;
   endfunction

   // Reset for 16 cycles and check that every handshake output is idle afterwards
   task automatic applyReset();
      reqCyc  <= 1'b0;
      respAck <= 1'b0;
      rstN    <= 1'b0;
      repeat (16) @(posedge cacheCoreBus);
      rstN <= 1'b1;
      @(posedge cacheCoreBus);
      foreach (modelValid[i]) begin
         modelValid[i] = 1'b0;
      end
      checkValue("reqAck", 64'(reqAck), 64'd0);
      checkValue("respCyc", 64'(respCyc), 64'd0);
      checkValue("memReqCyc", 64'(memReqCyc), 64'd0);
      checkValue("memRespAck", 64'(memRespAck), 64'd0);
   endtask

   // One core read from request to acknowledged response
   // preIssue raises the next request while this response is still held
   task automatic runAccess(input logic [`DMC_ADDR_BITS-1:0] addr,
                            input logic [`DMC_ADDR_BITS-1:0] nextAddr, input logic preIssue);
      dmCachePkg::addrFieldsT    f;
      logic                      predictHit;
      int                        countBefore;
      int                        cycles;
      int                        holdCycles;
      f           = dmCachePkg::addrFieldsT'(addr);
      predictHit  = modelValid[f.index] && (modelTag[f.index] == f.tag);
      countBefore = memReqCount;
      reqCyc   <= 1'b1;
      req.addr <= addr;
      cycles = 0;
      @(posedge cacheCoreBus);
      while (!reqAck && cycles < 100) begin
         cycles++;
         @(posedge cacheCoreBus);
      end
      if (!reqAck) begin
         abortRun("timeout waiting for reqAck");
      end
      reqCyc <= 1'b0;
      // Edges from reqAck to respCyc
      cycles = 0;
      while (!respCyc && cycles < 400) begin
         cycles++;
         @(posedge cacheCoreBus);
      end
      if (!respCyc) begin
         abortRun(stubStuck ? "arbiter stub never got memRespAck" : "timeout waiting for respCyc");
      end
      checkValue("resp", resp.data, expectedWord(addr));
      if (predictHit) begin
         checkValue("respCyc delay after reqAck", 64'(cycles), 64'd2);
         checkValue("memReq count", 64'(memReqCount - countBefore), 64'd0);
      end else begin
         checkValue("memReq count", 64'(memReqCount - countBefore), 64'd1);
         checkValue("memReq.addr", 64'(lastMemAddr),
                    64'({addr[`DMC_ADDR_BITS-1:`DMC_OFFSET_BITS], `DMC_OFFSET_BITS'(0)}));
      end
      // Response must stay put and no new request be accepted while respAck is held off
      holdCycles = $urandom % 9;
      if (preIssue) begin
         reqCyc   <= 1'b1;
         req.addr <= nextAddr;
      end
      for (int i = 0; i < holdCycles; i++) begin
         @(posedge cacheCoreBus);
         checkValue("respCyc", 64'(respCyc), 64'd1);
         checkValue("resp", resp.data, expectedWord(addr));
         checkValue("reqAck", 64'(reqAck), 64'd0);
      end
      respAck <= 1'b1;
      @(posedge cacheCoreBus);
      respAck <= 1'b0;
      checkValue("reqAck", 64'(reqAck), 64'd0);
      @(posedge cacheCoreBus);
      checkValue("respCyc", 64'(respCyc), 64'd0);
      checkValue("reqAck", 64'(reqAck), 64'd0);
      modelValid[f.index] = 1'b1;
      modelTag[f.index]   = f.tag;
   endtask

   initial begin
      seedValue  = $urandom(80411);
      rstN       = 1'b0;
      reqCyc     = 1'b0;
      req        = '0;
      respAck    = 1'b0;
      tagPool[0] = `DMC_TAG_BITS'('h0000005);
      tagPool[1] = `DMC_TAG_BITS'('h1234567);
      tagPool[2] = `DMC_TAG_BITS'('h0abcdef);
      applyReset();
      // Each index misses exactly once in a cold cache
      for (int i = 0; i < 16; i++) begin
         runAccess(makeAddr(0, i, $urandom % 8), '0, 1'b0);
      end
      // Tag 1 evicts tag 0 at index 5 and tag 0 then misses again
      runAccess(makeAddr(1, 5, 2), '0, 1'b0);
      runAccess(makeAddr(0, 5, 6), '0, 1'b0);
      // Random mix over eight lines and three tags
      for (int i = 0; i < 200; i++) begin
         randAddrs[i] = makeAddr($urandom % 3, $urandom % 8, $urandom % 8);
      end
      for (int i = 0; i < 200; i++) begin
         runAccess(randAddrs[i], randAddrs[(i + 1) % 200], i < 199);
      end
      // Line that hits before a reset must miss after it
      runAccess(makeAddr(2, 9, 1), '0, 1'b0);
      runAccess(makeAddr(2, 9, 4), '0, 1'b0);
      applyReset();
      runAccess(makeAddr(2, 9, 4), '0, 1'b0);
      $display("PASS: all tests");
      $finish;
   end

endmodule

/* verif/arbiterStub.sv */
`include "dmCache_settings.svh"

module arbiterStub (
   input  logic                cacheCoreBus,
   input  logic                memReqCyc,
   input  dmCachePkg::memReqT  memReq,
   output logic                memReqAck,
   output logic                memRespCyc,
   output dmCachePkg::memRespT memResp,
   input  logic                memRespAck,
   output logic                stuck
);

   // Line address taken from the accepted request
   logic [`DMC_ADDR_BITS-1:0] lineAddr;
   int                        cycles;

   // Memory contents, address on top and its inverse below
   function automatic logic [`DMC_WORD_BITS-1:0] wordAt(input logic [`DMC_ADDR_BITS-1:0] addr);
      return {addr, ~addr};
   endfunction

   // Random pause of 0 to 5 cycles before a handshake step
   task automatic randomPause();
      int pause;
      pause = $urandom % 6;
      repeat (pause) @(posedge cacheCoreBus);
   endtask

   initial begin
      memReqAck  = 1'b0;
      memRespCyc = 1'b0;
      memResp    = '0;
      stuck      = 1'b0;
      forever begin
         @(posedge cacheCoreBus);
         if (memReqCyc) begin
            lineAddr = memReq.addr;
            randomPause();
            // One-cycle acknowledge, the cache drops memReqCyc on the next edge
            memReqAck <= 1'b1;
            @(posedge cacheCoreBus);
            memReqAck <= 1'b0;
            // Eight words in order, each held until memRespAck
            for (int w = 0; w < `DMC_LINE_WORDS; w++) begin
               randomPause();
               memRespCyc   <= 1'b1;
               memResp.data <= wordAt(lineAddr + `DMC_ADDR_BITS'(w));
               cycles = 0;
               @(posedge cacheCoreBus);
               while (!memRespAck && cycles < 50) begin
                  cycles++;
                  @(posedge cacheCoreBus);
               end
               // No ack at all means the cache lost the fill
               if (!memRespAck) begin
                  stuck <= 1'b1;
               end
               memRespCyc <= 1'b0;
               @(posedge cacheCoreBus);
            end
         end
      end
   end

endmodule

/* src/dmCache.sv */
module dmCache (
   input  logic                 cacheCoreBus,
   input  logic                 rstN,
   input  logic                 reqCyc,
   input  dmCachePkg::coreReqT  req,
   output logic                 reqAck,
   output logic                 respCyc,
   output dmCachePkg::coreRespT resp,
   input  logic                 respAck,
   output logic                 memReqCyc,
   output dmCachePkg::memReqT   memReq,
   input  logic                 memReqAck,
   input  logic                 memRespCyc,
   input  dmCachePkg::memRespT  memResp,
   output logic                 memRespAck
);

   // Lookup handshake
   logic                   accept;
   logic                   hit;
   dmCachePkg::addrFieldsT fields;

   // Fill path
   logic                  fillDone;
   dmCachePkg::cacheLineT fillLine;

   // Response path
   dmCachePkg::coreRespT hitWord;
   dmCachePkg::coreRespT fillWord;
   logic                 loadHit;
   logic                 loadFill;
   logic                 respBusy;

   tagDirectory tagDirectory_i (
      .cacheCoreBus (cacheCoreBus),
      .rstN         (rstN),
      .accept       (accept),
      .req          (req),
      .fillDone     (fillDone),
      .fields       (fields),
      .hit          (hit)
   );

   lineStore lineStore_i (
      .cacheCoreBus (cacheCoreBus),
      .req          (req),
      .accept       (accept),
      .fields       (fields),
      .fillDone     (fillDone),
      .fillLine     (fillLine),
      .hitWord      (hitWord)
   );

   // Owns both the core request side and the arbiter side
   fillController fillController_i (
      .cacheCoreBus (cacheCoreBus),
      .rstN         (rstN),
      .reqCyc       (reqCyc),
      .reqAck       (reqAck),
      .hit          (hit),
      .fields       (fields),
      .respBusy     (respBusy),
      .memReqCyc    (memReqCyc),
      .memReq       (memReq),
      .memReqAck    (memReqAck),
      .memRespCyc   (memRespCyc),
      .memResp      (memResp),
      .memRespAck   (memRespAck),
      .accept       (accept),
      .fillDone     (fillDone),
      .fillLine     (fillLine),
      .fillWord     (fillWord),
      .loadHit      (loadHit),
      .loadFill     (loadFill)
   );

   responseHold responseHold_i (
      .cacheCoreBus (cacheCoreBus),
      .rstN         (rstN),
      .loadHit      (loadHit),
      .loadFill     (loadFill),
      .hitWord      (hitWord),
      .fillWord     (fillWord),
      .respAck      (respAck),
      .respCyc      (respCyc),
      .resp         (resp),
      .respBusy     (respBusy)
   );

endmodule

/* src/responseHold.sv */
module responseHold (
   input  logic                 cacheCoreBus,
   input  logic                 rstN,
   input  logic                 loadHit,
   input  logic                 loadFill,
   input  dmCachePkg::coreRespT hitWord,
   input  dmCachePkg::coreRespT fillWord,
   input  logic                 respAck,
   output logic                 respCyc,
   output dmCachePkg::coreRespT resp,
   output logic                 respBusy
);

   // Response strobe
   // Rises on a load, falls on the edge after respAck
   always_ff @(posedge cacheCoreBus or negedge rstN) begin
      if (!rstN) begin
         respCyc <= 1'b0;
      end else if (loadHit || loadFill) begin
         respCyc <= 1'b1;
      end else if (respCyc && respAck) begin
         respCyc <= 1'b0;
      end
   end

   // Response word, frozen between loads
   // Hit and fill loads never coincide
   always_ff @(posedge cacheCoreBus) begin
      if (loadHit) begin
         resp <= hitWord;
      end else if (loadFill) begin
         resp <= fillWord;
      end
   end

   // Pending response holds the controller in respond
   assign respBusy = respCyc;

endmodule

/* src/fillController.sv */
`include "dmCache_settings.svh"

module fillController (
   input  logic                   cacheCoreBus,
   input  logic                   rstN,
   input  logic                   reqCyc,
   output logic                   reqAck,
   input  logic                   hit,
   input  dmCachePkg::addrFieldsT fields,
   input  logic                   respBusy,
   output logic                   memReqCyc,
   output dmCachePkg::memReqT     memReq,
   input  logic                   memReqAck,
   input  logic                   memRespCyc,
   input  dmCachePkg::memRespT    memResp,
   output logic                   memRespAck,
   output logic                   accept,
   output logic                   fillDone,
   output dmCachePkg::cacheLineT  fillLine,
   output dmCachePkg::coreRespT   fillWord,
   output logic                   loadHit,
   output logic                   loadFill
);

   dmCachePkg::cacheStateT state;

   // Next word slot in the fill buffer
   logic [`DMC_OFFSET_BITS-1:0] wordCount;

   // Line being assembled from the arbiter
   dmCachePkg::cacheLineT fillBuf;

   logic takeWord;
   logic lastWord;
   logic missSeen;

   // Lookup second cycle, accept already dropped, directory answer valid
   assign loadHit  = (state == dmCachePkg::lookup) && !accept && hit;
   assign missSeen = (state == dmCachePkg::lookup) && !accept && !hit;

   // A word is taken once per memRespCyc, ack blocks a double take
   assign takeWord = (state == dmCachePkg::fetchMemory) && memRespCyc && !memRespAck;
   assign lastWord = wordCount == `DMC_OFFSET_BITS'(`DMC_LINE_WORDS - 1);

   always_ff @(posedge cacheCoreBus or negedge rstN) begin
      if (!rstN) begin
         state      <= dmCachePkg::idle;
         reqAck     <= 1'b0;
         accept     <= 1'b0;
         memReqCyc  <= 1'b0;
         memRespAck <= 1'b0;
         wordCount  <= '0;
         fillDone   <= 1'b0;
         loadFill   <= 1'b0;
      end else begin
         // Pulses default low
         reqAck     <= 1'b0;
         accept     <= 1'b0;
         memRespAck <= 1'b0;
         fillDone   <= 1'b0;
         loadFill   <= 1'b0;
         case (state)
            dmCachePkg::idle: begin
               if (reqCyc) begin
                  reqAck <= 1'b1;
                  accept <= 1'b1;
                  state  <= dmCachePkg::lookup;
               end
            end
            dmCachePkg::lookup: begin
               // First cycle only lets the directory latch
               if (loadHit) begin
                  state <= dmCachePkg::respond;
               end else if (missSeen) begin
                  memReqCyc <= 1'b1;
                  wordCount <= '0;
                  state     <= dmCachePkg::fetchMemory;
               end
            end
            dmCachePkg::fetchMemory: begin
               if (memReqCyc && memReqAck) begin
                  memReqCyc <= 1'b0;
               end
               if (takeWord) begin
                  memRespAck <= 1'b1;
                  wordCount  <= wordCount + `DMC_OFFSET_BITS'(1);
                  // Eighth word, line complete
                  if (lastWord) begin
                     fillDone <= 1'b1;
                     loadFill <= 1'b1;
                     state    <= dmCachePkg::respond;
                  end
               end
            end
            dmCachePkg::respond: begin
               // fillDone marks the cycle before respCyc rises on a miss
               if (!respBusy && !fillDone) begin
                  state <= dmCachePkg::idle;
               end
            end
            default: begin
               state <= dmCachePkg::idle;
            end
         endcase
      end
   end

   // Line-aligned miss address, held through the request handshake
   always_ff @(posedge cacheCoreBus) begin
      if (missSeen) begin
         memReq.addr <= {fields.tag, fields.index, {`DMC_OFFSET_BITS{1'b0}}};
      end
   end

   // Fill buffer, filled in word order
   always_ff @(posedge cacheCoreBus) begin
      if (takeWord) begin
         fillBuf.words[wordCount] <= memResp.data;
      end
   end

   assign fillLine      = fillBuf;
   // Requested word picked out of the fresh line
   assign fillWord.data = fillBuf.words[fields.offset];

endmodule

/* src/lineStore.sv */
`include "dmCache_settings.svh"

module lineStore (
   input  logic                   cacheCoreBus,
   input  dmCachePkg::coreReqT    req,
   input  logic                   accept,
   input  dmCachePkg::addrFieldsT fields,
   input  logic                   fillDone,
   input  dmCachePkg::cacheLineT  fillLine,
   output dmCachePkg::coreRespT   hitWord
);

   // Data array, one full line per index
   dmCachePkg::cacheLineT lines [(1 << `DMC_INDEX_BITS)];

   // Read address taken straight from the core request
   dmCachePkg::addrFieldsT reqFields;

   assign reqFields = dmCachePkg::addrFieldsT'(req.addr);

   // Single-word read, one cycle after accept
   // Read data is stale on a miss and gets ignored then
   always_ff @(posedge cacheCoreBus) begin
      if (accept) begin
         hitWord.data <= lines[reqFields.index].words[reqFields.offset];
      end
   end

   // Whole-line write at the end of a fill
   // Index comes from the directory latch, core may have moved on
   always_ff @(posedge cacheCoreBus) begin
      if (fillDone) begin
         lines[fields.index] <= fillLine;
      end
   end

endmodule

/* src/tagDirectory.sv */
`include "dmCache_settings.svh"

module tagDirectory (
   input  logic                   cacheCoreBus,
   input  logic                   rstN,
   input  logic                   accept,
   input  dmCachePkg::coreReqT    req,
   input  logic                   fillDone,
   output dmCachePkg::addrFieldsT fields,
   output logic                   hit
);

   // One valid bit per line, cleared by reset
   logic [(1 << `DMC_INDEX_BITS)-1:0] valid;

   // Tag array, only meaningful where valid is set
   logic [`DMC_TAG_BITS-1:0] tags [(1 << `DMC_INDEX_BITS)];

   // Incoming address split into fields
   dmCachePkg::addrFieldsT reqFields;

   // Registered directory read for the latched index
   logic                     validRd;
   logic [`DMC_TAG_BITS-1:0] tagRd;

   assign reqFields = dmCachePkg::addrFieldsT'(req.addr);

   // Valid bits and their read port
   always_ff @(posedge cacheCoreBus or negedge rstN) begin
      if (!rstN) begin
         valid   <= '0;
         validRd <= 1'b0;
      end else begin
         if (accept) begin
            validRd <= valid[reqFields.index];
         end
         // Fill completes the line at the index latched on accept
         if (fillDone) begin
            valid[fields.index] <= 1'b1;
         end
      end
   end

   // Request latch and tag array
   always_ff @(posedge cacheCoreBus) begin
      if (accept) begin
         fields <= reqFields;
         tagRd  <= tags[reqFields.index];
      end
      if (fillDone) begin
         tags[fields.index] <= fields.tag;
      end
   end

   // Hit decision, valid one cycle after accept
   assign hit = validRd && (tagRd == fields.tag);

endmodule

/* src/dmCachePkg.sv */
`include "dmCache_settings.svh"

package dmCachePkg;

   // Word address viewed as cache fields
   // Field order matches the address bits, tag on top
   typedef struct packed {
      logic [`DMC_TAG_BITS-1:0]    tag;
      logic [`DMC_INDEX_BITS-1:0]  index;
      logic [`DMC_OFFSET_BITS-1:0] offset;
   } addrFieldsT;

   // Read request from the core
   typedef struct packed {
      logic [`DMC_ADDR_BITS-1:0] addr;
   } coreReqT;

   // Read data back to the core
   typedef struct packed {
      logic [`DMC_WORD_BITS-1:0] data;
   } coreRespT;

   // Line request to the arbiter, offset bits always zero
   typedef struct packed {
      logic [`DMC_ADDR_BITS-1:0] addr;
   } memReqT;

   // One word of a returned line
   typedef struct packed {
      logic [`DMC_WORD_BITS-1:0] data;
   } memRespT;

   // Whole line, words[0] in the low bits
   typedef struct packed {
      logic [`DMC_LINE_WORDS-1:0][`DMC_WORD_BITS-1:0] words;
   } cacheLineT;

   // Controller states
   // lookup spans two cycles: address latch, then hit decision
   typedef enum logic [1:0] {
      idle,
      lookup,
      fetchMemory,
      respond
   } cacheStateT;

endpackage

/* include/dmCache_settings.svh */
`ifndef DMCACHE_SETTINGS_SVH
`define DMCACHE_SETTINGS_SVH

// Word address width seen by the core and the arbiter
`define DMC_ADDR_BITS 32

// Data word width on both buses
`define DMC_WORD_BITS 64

// Line index width, 16 lines
`define DMC_INDEX_BITS 4

// Word offset inside a line
`define DMC_OFFSET_BITS 3

// Words per line, must equal 2**DMC_OFFSET_BITS
`define DMC_LINE_WORDS 8

// Tag is whatever is left above index and offset
`define DMC_TAG_BITS (`DMC_ADDR_BITS - `DMC_INDEX_BITS - `DMC_OFFSET_BITS)

`endif
